// File: source/issue_defines.svh
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// operand and tag widths
`define DATA_W         32
`define TAG_W          6

// data memory, word addressed through byte address bits 7:2
`define DMEM_DEPTH     64
`define DMEM_ADDR_W    6

// cycles from grant to broadcast
`define MULT_LATENCY   4
// div latency doubles as the reservation vector length
`define DIV_LATENCY    7

// apb byte addresses
`define REG_CTRL       8'h00
`define REG_BCAST_CNT  8'h04
`define REG_STALL_CNT  8'h08

`endif

// File: source/issue_pkg.sv
`include "issue_defines.svh"

package issue_pkg;

   // operand and result paths
   typedef logic [`DATA_W-1:0] data_t;

   // reservation station tag
   typedef logic [`TAG_W-1:0] tag_t;

   typedef logic [7:0] apb_addr_t;

   // integer unit operations, the two branches only set a taken flag
   typedef enum logic [3:0] {
      op_add = 4'd0,
      op_sub = 4'd1,
      op_and = 4'd2,
      op_or  = 4'd3,
      op_xor = 4'd4,
      op_slt = 4'd5,
      op_beq = 4'd6,
      op_bne = 4'd7
   } alu_op_t;

endpackage

// File: source/int_alu.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module int_alu
   import issue_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    issue,
   input  alu_op_t op,
   input  data_t   rs,
   input  data_t   rt,
   input  tag_t    tag,
   output data_t   res,
   output tag_t    res_tag,
   output logic    res_valid,
   output logic    is_branch,
   output logic    taken
);

   data_t alu_out;
   logic  branch_op;
   logic  branch_taken;

   always_comb begin
      alu_out      = '0;
      branch_op    = 1'b0;
      branch_taken = 1'b0;
      case (op)
         op_add: alu_out = rs + rt;
         op_sub: alu_out = rs - rt;
         op_and: alu_out = rs & rt;
         op_or:  alu_out = rs | rt;
         op_xor: alu_out = rs ^ rt;
         // signed compare, result is 1 or 0
         op_slt: alu_out = ($signed(rs) < $signed(rt)) ? data_t'(1) : '0;
         op_beq: begin
            branch_op    = 1'b1;
            branch_taken = (rs == rt);
         end
         op_bne: begin
            branch_op    = 1'b1;
            branch_taken = (rs != rt);
         end
         default: alu_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= issue;
      end
   end

   // result payload, only meaningful while res_valid is high
   always_ff @(posedge clk) begin
      res       <= alu_out;
      res_tag   <= tag;
      is_branch <= branch_op;
      taken     <= branch_taken;
   end

endmodule

// File: source/ls_data_cache.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module ls_data_cache
   import issue_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  issue,
   input  logic  store,
   input  data_t addr,
   input  data_t wdata,
   input  tag_t  tag,
   output data_t res,
   output tag_t  res_tag,
   output logic  res_valid
);

   data_t mem [`DMEM_DEPTH];
   logic [`DMEM_ADDR_W-1:0] word_addr;

   // byte address to word index
   assign word_addr = addr[`DMEM_ADDR_W+1:2];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `DMEM_DEPTH; i++) begin
            mem[i] <= '0;
         end
         res_valid <= 1'b0;
      end else begin
         if (issue && store) begin
            mem[word_addr] <= wdata;
         end
         // stores never broadcast
         res_valid <= issue & ~store;
      end
   end

   // registered read and tag
   always_ff @(posedge clk) begin
      res     <= mem[word_addr];
      res_tag <= tag;
   end

endmodule

// File: source/mult_pipe.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module mult_pipe
   import issue_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  issue,
   input  data_t rs,
   input  data_t rt,
   input  tag_t  tag,
   output data_t res,
   output tag_t  res_tag,
   output logic  res_valid
);

   data_t prod_q [`MULT_LATENCY];
   tag_t  tag_q  [`MULT_LATENCY];
   logic [`MULT_LATENCY-1:0] valid_q;
   data_t product;

   // low word of the unsigned product
   assign product = rs * rt;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[`MULT_LATENCY-2:0], issue};
      end
   end

   always_ff @(posedge clk) begin
      prod_q[0] <= product;
      tag_q[0]  <= tag;
      for (int i = 1; i < `MULT_LATENCY; i++) begin
         prod_q[i] <= prod_q[i-1];
         tag_q[i]  <= tag_q[i-1];
      end
   end

   assign res       = prod_q[`MULT_LATENCY-1];
   assign res_tag   = tag_q[`MULT_LATENCY-1];
   assign res_valid = valid_q[`MULT_LATENCY-1];

endmodule

// File: source/div_pipe.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module div_pipe
   import issue_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  issue,
   input  data_t rs,
   input  data_t rt,
   input  tag_t  tag,
   output data_t res,
   output tag_t  res_tag,
   output logic  res_valid
);

   data_t quot_q [`DIV_LATENCY];
   tag_t  tag_q  [`DIV_LATENCY];
   logic [`DIV_LATENCY-1:0] valid_q;
   data_t quotient;

   // unsigned divide, divide by zero saturates to all ones
   always_comb begin
      if (rt == '0) begin
         quotient = '1;
      end else begin
         quotient = rs / rt;
      end
   end

   // one issue per cycle can enter, results leave in order
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[`DIV_LATENCY-2:0], issue};
      end
   end

   always_ff @(posedge clk) begin
      quot_q[0] <= quotient;
      tag_q[0]  <= tag;
      for (int i = 1; i < `DIV_LATENCY; i++) begin
         quot_q[i] <= quot_q[i-1];
         tag_q[i]  <= tag_q[i-1];
      end
   end

   assign res       = quot_q[`DIV_LATENCY-1];
   assign res_tag   = tag_q[`DIV_LATENCY-1];
   assign res_valid = valid_q[`DIV_LATENCY-1];

endmodule

// File: source/cdb_arbiter.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module cdb_arbiter
   import issue_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  int_req,
   input  logic  ls_req,
   input  logic  mult_req,
   input  logic  div_req,
   input  logic  prio_int_first,
   output logic  int_grant,
   output logic  ls_grant,
   output logic  mult_grant,
   output logic  div_grant,
   output logic  stall,
   input  data_t int_res,
   input  tag_t  int_res_tag,
   input  logic  int_res_valid,
   input  logic  int_is_branch,
   input  logic  int_taken,
   input  data_t ls_res,
   input  tag_t  ls_res_tag,
   input  logic  ls_res_valid,
   input  data_t mult_res,
   input  tag_t  mult_res_tag,
   input  logic  mult_res_valid,
   input  data_t div_res,
   input  tag_t  div_res_tag,
   input  logic  div_res_valid,
   output logic  cdb_valid,
   output data_t cdb_data,
   output tag_t  cdb_tag,
   output logic  cdb_branch,
   output logic  cdb_branch_taken
);

   typedef enum logic {turn_int, turn_ls} turn_t;

   // bit 1 is the current cycle, bit k is k-1 cycles ahead
   logic [`DIV_LATENCY:1] reserved_r;
   logic [`DIV_LATENCY:1] reserved_next;
   turn_t turn_r;
   logic  short_free;
   logic  contended;
   logic  int_wins;

   always_comb begin
      // next cycle's slot, i.e. bit 1 after the shift
      short_free = ~reserved_r[2];
      contended  = int_req & ls_req & short_free;
      int_wins   = prio_int_first | (turn_r == turn_int);
      int_grant  = int_req & short_free & (~ls_req | int_wins);
      ls_grant   = ls_req & short_free & (~int_req | ~int_wins);
      mult_grant = mult_req & ~reserved_r[`MULT_LATENCY+1];
      div_grant  = div_req & ~reserved_r[`DIV_LATENCY];
      stall      = (int_req & ~int_grant) | (ls_req & ~ls_grant) |
                   (mult_req & ~mult_grant) | (div_req & ~div_grant);
   end

   always_comb begin
      reserved_next = {1'b0, reserved_r[`DIV_LATENCY:2]};
      if (int_grant || ls_grant) begin
         reserved_next[1] = 1'b1;
      end
      if (mult_grant) begin
         reserved_next[`MULT_LATENCY] = 1'b1;
      end
      if (div_grant) begin
         reserved_next[`DIV_LATENCY] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         reserved_r <= '0;
         turn_r     <= turn_int;
      end else begin
         reserved_r <= reserved_next;
         // toggle only counts contention in alternate mode
         if (contended && !prio_int_first) begin
            turn_r <= (turn_r == turn_int) ? turn_ls : turn_int;
         end
      end
   end

   // valids are one-hot inside an owned slot
   always_comb begin
      cdb_valid        = 1'b0;
      cdb_data         = '0;
      cdb_tag          = '0;
      cdb_branch       = 1'b0;
      cdb_branch_taken = 1'b0;
      if (reserved_r[1]) begin
         case ({int_res_valid, ls_res_valid, mult_res_valid, div_res_valid})
            4'b1000: begin
               cdb_valid        = ~int_is_branch;
               cdb_data         = int_res;
               cdb_tag          = int_res_tag;
               cdb_branch       = int_is_branch;
               cdb_branch_taken = int_is_branch & int_taken;
            end
            4'b0100: begin
               cdb_valid = 1'b1;
               cdb_data  = ls_res;
               cdb_tag   = ls_res_tag;
            end
            4'b0010: begin
               cdb_valid = 1'b1;
               cdb_data  = mult_res;
               cdb_tag   = mult_res_tag;
            end
            4'b0001: begin
               cdb_valid = 1'b1;
               cdb_data  = div_res;
               cdb_tag   = div_res_tag;
            end
            // store slot or idle
            default: cdb_valid = 1'b0;
         endcase
      end
   end

endmodule

// File: source/issue_regs.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_regs
   import issue_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  data_t     pwdata,
   output data_t     prdata,
   output logic      pready,
   output logic      pslverr,
   input  logic      cdb_valid,
   input  logic      stall,
   output logic      prio_int_first
);

   data_t bcast_cnt;
   data_t stall_cnt;
   logic  access;
   logic  wr;
   logic  addr_ok;

   assign access  = psel & penable;
   assign wr      = access & pwrite;
   assign addr_ok = (paddr == `REG_CTRL) || (paddr == `REG_BCAST_CNT) ||
                    (paddr == `REG_STALL_CNT);

   // no wait states
   assign pready  = 1'b1;
   assign pslverr = access & ~addr_ok;

   always_ff @(posedge clk) begin
      if (reset) begin
         prio_int_first <= 1'b0;
         bcast_cnt      <= '0;
         stall_cnt      <= '0;
      end else begin
         if (wr && paddr == `REG_CTRL) begin
            prio_int_first <= pwdata[0];
         end
         // a write of any value clears a counter
         if (wr && paddr == `REG_BCAST_CNT) begin
            bcast_cnt <= '0;
         end else if (cdb_valid) begin
            bcast_cnt <= bcast_cnt + 1'b1;
         end
         if (wr && paddr == `REG_STALL_CNT) begin
            stall_cnt <= '0;
         end else if (stall) begin
            stall_cnt <= stall_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      case (paddr)
         `REG_CTRL:      prdata = {{(`DATA_W-1){1'b0}}, prio_int_first};
         `REG_BCAST_CNT: prdata = bcast_cnt;
         `REG_STALL_CNT: prdata = stall_cnt;
         default:        prdata = '0;
      endcase
   end

endmodule

// File: source/issue_unit.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_unit
   import issue_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      int_req,
   input  alu_op_t   int_op,
   input  data_t     int_rs,
   input  data_t     int_rt,
   input  tag_t      int_tag,
   output logic      int_grant,
   input  logic      ls_req,
   input  logic      ls_store,
   input  data_t     ls_addr,
   input  data_t     ls_data,
   input  tag_t      ls_tag,
   output logic      ls_grant,
   input  logic      mult_req,
   input  data_t     mult_rs,
   input  data_t     mult_rt,
   input  tag_t      mult_tag,
   output logic      mult_grant,
   input  logic      div_req,
   input  data_t     div_rs,
   input  data_t     div_rt,
   input  tag_t      div_tag,
   output logic      div_grant,
   output logic      cdb_valid,
   output data_t     cdb_data,
   output tag_t      cdb_tag,
   output logic      cdb_branch,
   output logic      cdb_branch_taken,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  data_t     pwdata,
   output data_t     prdata,
   output logic      pready,
   output logic      pslverr
);

   // unit results back to the arbiter
   data_t int_res, ls_res, mult_res, div_res;
   tag_t  int_res_tag, ls_res_tag, mult_res_tag, div_res_tag;
   logic  int_res_valid, ls_res_valid, mult_res_valid, div_res_valid;
   logic  int_is_branch;
   logic  int_taken;
   logic  prio_int_first;
   logic  stall;

   cdb_arbiter u_cdb_arbiter (
      .clk, .reset,
      .int_req, .ls_req, .mult_req, .div_req,
      .prio_int_first,
      .int_grant, .ls_grant, .mult_grant, .div_grant,
      .stall,
      .int_res, .int_res_tag, .int_res_valid, .int_is_branch, .int_taken,
      .ls_res, .ls_res_tag, .ls_res_valid,
      .mult_res, .mult_res_tag, .mult_res_valid,
      .div_res, .div_res_tag, .div_res_valid,
      .cdb_valid, .cdb_data, .cdb_tag, .cdb_branch, .cdb_branch_taken
   );

   // grants double as issue strobes
   int_alu u_int_alu (
      .clk, .reset,
      .issue     (int_grant),
      .op        (int_op),
      .rs        (int_rs),
      .rt        (int_rt),
      .tag       (int_tag),
      .res       (int_res),
      .res_tag   (int_res_tag),
      .res_valid (int_res_valid),
      .is_branch (int_is_branch),
      .taken     (int_taken)
   );

   ls_data_cache u_ls_data_cache (
      .clk, .reset,
      .issue     (ls_grant),
      .store     (ls_store),
      .addr      (ls_addr),
      .wdata     (ls_data),
      .tag       (ls_tag),
      .res       (ls_res),
      .res_tag   (ls_res_tag),
      .res_valid (ls_res_valid)
   );

   mult_pipe u_mult_pipe (
      .clk, .reset,
      .issue     (mult_grant),
      .rs        (mult_rs),
      .rt        (mult_rt),
      .tag       (mult_tag),
      .res       (mult_res),
      .res_tag   (mult_res_tag),
      .res_valid (mult_res_valid)
   );

   div_pipe u_div_pipe (
      .clk, .reset,
      .issue     (div_grant),
      .rs        (div_rs),
      .rt        (div_rt),
      .tag       (div_tag),
      .res       (div_res),
      .res_tag   (div_res_tag),
      .res_valid (div_res_valid)
   );

   issue_regs u_issue_regs (
      .clk, .reset,
      .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pslverr,
      .cdb_valid, .stall,
      .prio_int_first
   );

endmodule

// File: tests/issue_unit_tb.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_unit_tb
   import issue_pkg::*;
();

   localparam int unit_int  = 0;
   localparam int unit_ls   = 1;
   localparam int unit_mult = 2;
   localparam int unit_div  = 3;
   // directed entries come first and alternate mode ends at n_alt
   localparam int n_alt      = 24;
   localparam int n_directed = 28;
   localparam int n_entries  = 52;

   logic      clk;
   logic      reset;
   logic      int_req, ls_req, mult_req, div_req;
   logic      int_grant, ls_grant, mult_grant, div_grant;
   alu_op_t   int_op;
   data_t     int_rs, int_rt, ls_addr, ls_data, mult_rs, mult_rt, div_rs, div_rt;
   tag_t      int_tag, ls_tag, mult_tag, div_tag;
   logic      ls_store;
   logic      cdb_valid, cdb_branch, cdb_branch_taken;
   data_t     cdb_data;
   tag_t      cdb_tag;
   logic      psel, penable, pwrite, pready, pslverr;
   apb_addr_t paddr;
   data_t     pwdata, prdata;

   // stimulus table
   // for ls the store flag sits in bit 0 of the op column
   int         t_unit [n_entries];
   logic [3:0] t_op   [n_entries];
   data_t      t_a    [n_entries];
   data_t      t_b    [n_entries];
   data_t      t_addr [n_entries];
   bit         t_next [n_entries];
   int         t_gap  [n_entries];
   int         t_wait [n_entries];
   string      t_name [n_entries];
   int         n_added = 0;

   // expected broadcasts by cycle number modulo 16
   int    exp_kind  [16];
   data_t exp_data  [16];
   tag_t  exp_tag   [16];
   logic  exp_taken [16];
   string exp_name  [16];

   data_t       model_mem [`DMEM_DEPTH];
   logic [31:0] lcg_state  = 32'h4414;
   int          cycle_cnt  = 0;
   int          bcast_seen = 0;
   int          stall_seen = 0;

   issue_unit u_issue_unit (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   task automatic report_error(input string what);
      $display("%s", what);
      $display("Something failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         report_error($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
      end
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic data_t alu_model(input logic [3:0] op, input data_t a, input data_t b);
      case (op)
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         op_or:   return a | b;
         op_xor:  return a ^ b;
         op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default: return '0;
      endcase
   endfunction

   function automatic logic grant_of(input int unit);
      case (unit)
         unit_int:  return int_grant;
         unit_ls:   return ls_grant;
         unit_mult: return mult_grant;
         default:   return div_grant;
      endcase
   endfunction

   task automatic add_entry(input int unit, input logic [3:0] op, input data_t a,
                            input data_t b, input data_t addr, input bit with_next,
                            input int gap, input int exp_wait, input string name);
      t_unit[n_added] = unit;
      t_op[n_added]   = op;
      t_a[n_added]    = a;
      t_b[n_added]    = b;
      t_addr[n_added] = addr;
      t_next[n_added] = with_next;
      t_gap[n_added]  = gap;
      t_wait[n_added] = exp_wait;
      t_name[n_added] = name;
      n_added++;
   endtask

   task automatic build_table();
      logic [31:0] r;
      int          k;
      add_entry(unit_int, op_add, 32'h1234_5678, 32'h1111_1111, '0, 0, 0, -1, "alu add");
      add_entry(unit_int, op_sub, 32'd5, 32'd9, '0, 0, 0, -1, "alu sub");
      add_entry(unit_int, op_and, 32'hf0f0_ff00, 32'h3c3c_0ff0, '0, 0, 0, -1, "alu and");
      add_entry(unit_int, op_or, 32'hf0f0_ff00, 32'h3c3c_0ff0, '0, 0, 0, -1, "alu or");
      add_entry(unit_int, op_xor, 32'hf0f0_ff00, 32'h3c3c_0ff0, '0, 0, 0, -1, "alu xor");
      add_entry(unit_int, op_slt, 32'hffff_fff0, 32'd3, '0, 0, 0, -1, "alu slt negative");
      add_entry(unit_int, op_slt, 32'd3, 32'hffff_fff0, '0, 0, 0, -1, "alu slt positive");
      // int and ls together so the winner alternates
      add_entry(unit_int, op_or, 32'h00ff, 32'hff00, '0, 1, 0, 0, "alternate 1 int");
      add_entry(unit_ls, 4'd0, '0, '0, 32'h0, 0, 0, 1, "alternate 1 ls");
      add_entry(unit_int, op_add, 32'd7, 32'd8, '0, 1, 0, 1, "alternate 2 int");
      add_entry(unit_ls, 4'd0, '0, '0, 32'h4, 0, 0, 0, "alternate 2 ls");
      add_entry(unit_int, op_beq, 32'd42, 32'd42, '0, 0, 0, -1, "beq taken");
      add_entry(unit_int, op_beq, 32'd1, 32'd2, '0, 0, 0, -1, "beq not taken");
      add_entry(unit_int, op_bne, 32'd3, 32'd4, '0, 0, 0, -1, "bne taken");
      add_entry(unit_ls, 4'd1, 32'hcafe_0010, '0, 32'h10, 0, 0, -1, "store 0x10");
      add_entry(unit_ls, 4'd0, '0, '0, 32'h10, 0, 0, -1, "load 0x10");
      add_entry(unit_ls, 4'd1, 32'h5a5a_a5a5, '0, 32'h24, 0, 0, -1, "store 0x24");
      add_entry(unit_ls, 4'd0, '0, '0, 32'h24, 0, 0, -1, "load 0x24");
      add_entry(unit_mult, 4'd0, 32'd1234, 32'd5678, '0, 0, 0, -1, "mult small");
      add_entry(unit_mult, 4'd0, 32'hffff_ffff, 32'hffff_ffff, '0, 0, 0, -1, "mult wraps");
      add_entry(unit_div, 4'd0, 32'd100, 32'd7, '0, 0, 0, -1, "div small");
      add_entry(unit_div, 4'd0, 32'd77, 32'd0, '0, 0, 0, -1, "div by zero");
      add_entry(unit_div, 4'd0, 32'hffff_0000, 32'd3, '0, 0, 0, -1, "div before mult");
      // mult slot collides with the div three cycles after its grant
      add_entry(unit_mult, 4'd0, 32'd9, 32'd11, '0, 0, 2, 1, "mult behind div");
      add_entry(unit_int, op_xor, 32'h55, 32'h0f, '0, 1, 0, 0, "int first 1 int");
      add_entry(unit_ls, 4'd0, '0, '0, 32'h10, 0, 0, 1, "int first 1 ls");
      add_entry(unit_int, op_sub, 32'd100, 32'd1, '0, 1, 0, 0, "int first 2 int");
      add_entry(unit_ls, 4'd0, '0, '0, 32'h24, 0, 0, 1, "int first 2 ls");
      for (k = n_directed; k < n_entries; k++) begin
         r = lcg_next();
         add_entry(int'(r[31:30]), {1'b0, r[26:24]}, lcg_next(), lcg_next() >> r[20:16],
                   data_t'({r[12:10], 2'b00}), 0, 0, -1, $sformatf("random entry %0d", k));
      end
      // random pairs fire together when their units differ
      for (k = n_directed; k + 1 < n_entries; k += 2) begin
         t_next[k] = (t_unit[k] != t_unit[k+1]);
      end
   endtask

   task automatic set_req(input int unit, input logic value);
      case (unit)
         unit_int:  int_req  = value;
         unit_ls:   ls_req   = value;
         unit_mult: mult_req = value;
         default:   div_req  = value;
      endcase
   endtask

   task automatic drive_entry(input int k);
      case (t_unit[k])
         unit_int: begin
            int_op  = alu_op_t'(t_op[k]);
            int_rs  = t_a[k];
            int_rt  = t_b[k];
            int_tag = tag_t'(k);
         end
         unit_ls: begin
            ls_store = t_op[k][0];
            ls_addr  = t_addr[k];
            ls_data  = t_a[k];
            ls_tag   = tag_t'(k);
         end
         unit_mult: begin
            mult_rs  = t_a[k];
            mult_rt  = t_b[k];
            mult_tag = tag_t'(k);
         end
         default: begin
            div_rs  = t_a[k];
            div_rt  = t_b[k];
            div_tag = tag_t'(k);
         end
      endcase
      set_req(t_unit[k], 1'b1);
   endtask

   // reference model at the grant puts the result in its broadcast cycle
   task automatic record_grant(input int k);
      int    lat;
      int    kind;
      int    slot;
      data_t value;
      logic  taken;
      lat   = 1;
      kind  = 1;
      value = '0;
      taken = 1'b0;
      case (t_unit[k])
         unit_int: begin
            if (t_op[k] == op_beq || t_op[k] == op_bne) begin
               kind  = 2;
               taken = (t_op[k] == op_beq) ? (t_a[k] == t_b[k]) : (t_a[k] != t_b[k]);
            end else begin
               value = alu_model(t_op[k], t_a[k], t_b[k]);
            end
         end
         unit_ls: begin
            if (t_op[k][0]) begin
               model_mem[t_addr[k][7:2]] = t_a[k];
               kind = 0;
            end else begin
               value = model_mem[t_addr[k][7:2]];
            end
         end
         unit_mult: begin
            lat   = `MULT_LATENCY;
            value = t_a[k] * t_b[k];
         end
         default: begin
            lat   = `DIV_LATENCY;
            value = (t_b[k] == 0) ? '1 : t_a[k] / t_b[k];
         end
      endcase
      if (kind != 0) begin
         slot = (cycle_cnt + lat) % 16;
         if (exp_kind[slot] != 0) begin
            report_error($sformatf("%s was granted into a CDB cycle already taken", t_name[k]));
         end
         exp_kind[slot]  = kind;
         exp_data[slot]  = value;
         exp_tag[slot]   = tag_t'(k);
         exp_taken[slot] = taken;
         exp_name[slot]  = t_name[k];
      end
   endtask

   task automatic run_entries(input int first, input int last);
      int i;
      int j;
      int k;
      int left;
      bit any_refused;
      bit pending [n_entries];
      bit granted [n_entries];
      int refused [n_entries];
      i = first;
      while (i < last) begin
         j = i;
         while (t_next[j] && j + 1 < last) j++;
         repeat (t_gap[i]) begin
            @(posedge clk);
            #1;
         end
         for (k = i; k <= j; k++) begin
            drive_entry(k);
            pending[k] = 1'b1;
            refused[k] = 0;
         end
         left = j - i + 1;
         while (left > 0) begin
            @(negedge clk);
            any_refused = 1'b0;
            for (k = i; k <= j; k++) begin
               granted[k] = 1'b0;
               if (pending[k] && grant_of(t_unit[k])) begin
                  record_grant(k);
                  granted[k] = 1'b1;
                  pending[k] = 1'b0;
                  left--;
               end else if (pending[k]) begin
                  refused[k]++;
                  any_refused = 1'b1;
               end
            end
            if (any_refused) stall_seen++;
            @(posedge clk);
            #1;
            for (k = i; k <= j; k++) begin
               if (granted[k]) set_req(t_unit[k], 1'b0);
            end
         end
         for (k = i; k <= j; k++) begin
            if (t_wait[k] >= 0) begin
               check_value({t_name[k], " refused cycles"}, t_wait[k], refused[k]);
            end
         end
         i = j + 1;
      end
   endtask

   task automatic apb_access(input apb_addr_t addr, input logic write, input data_t wdata,
                             output data_t rdata, output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      check_value("apb pready", 1, pready);
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic drain();
      repeat (10) begin
         @(posedge clk);
         #1;
      end
   endtask

   always @(negedge clk) begin : cdb_monitor
      int slot;
      if (!reset) begin
         slot = cycle_cnt % 16;
         if (exp_kind[slot] == 0) begin
            if (cdb_valid || cdb_branch || cdb_branch_taken ||
                cdb_data != 0 || cdb_tag != 0) begin
               report_error($sformatf("CDB activity in cycle %0d with nothing expected",
                                      cycle_cnt));
            end
         end else begin
            check_value({exp_name[slot], " cdb_valid"}, exp_kind[slot] == 1, cdb_valid);
            check_value({exp_name[slot], " cdb_branch"}, exp_kind[slot] == 2, cdb_branch);
            check_value({exp_name[slot], " taken"}, exp_taken[slot], cdb_branch_taken);
            check_value({exp_name[slot], " data"}, exp_data[slot], cdb_data);
            check_value({exp_name[slot], " tag"}, exp_tag[slot], cdb_tag);
            if (exp_kind[slot] == 1) bcast_seen++;
            exp_kind[slot] = 0;
         end
      end
   end

   initial begin : watchdog
      repeat (20 * n_entries + 200) @(posedge clk);
      report_error($sformatf("timeout, the run did not finish in %0d cycles",
                             20 * n_entries + 200));
   end

   initial begin
      data_t rdata;
      logic  err;
      int    missing;
      reset    = 1'b1;
      int_req  = 1'b0;
      ls_req   = 1'b0;
      mult_req = 1'b0;
      div_req  = 1'b0;
      int_op   = op_add;
      int_rs   = '0;
      int_rt   = '0;
      int_tag  = '0;
      ls_store = 1'b0;
      ls_addr  = '0;
      ls_data  = '0;
      ls_tag   = '0;
      mult_rs  = '0;
      mult_rt  = '0;
      mult_tag = '0;
      div_rs   = '0;
      div_rt   = '0;
      div_tag  = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      foreach (exp_kind[s]) exp_kind[s] = 0;
      foreach (model_mem[m]) model_mem[m] = '0;
      build_table();
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      run_entries(0, n_alt);
      drain();
      // switch to int-first
      apb_access(`REG_CTRL, 1'b1, 32'd1, rdata, err);
      apb_access(`REG_CTRL, 1'b0, '0, rdata, err);
      check_value("ctrl readback", 32'd1, rdata);
      run_entries(n_alt, n_entries);
      drain();

      apb_access(`REG_BCAST_CNT, 1'b0, '0, rdata, err);
      check_value("broadcast counter", bcast_seen, rdata);
      check_value("broadcast counter pslverr", 0, err);
      apb_access(`REG_STALL_CNT, 1'b0, '0, rdata, err);
      check_value("stall counter", stall_seen, rdata);
      apb_access(`REG_BCAST_CNT, 1'b1, 32'hffff, rdata, err);
      apb_access(`REG_STALL_CNT, 1'b1, 32'hffff, rdata, err);
      bcast_seen = 0;
      stall_seen = 0;
      apb_access(`REG_BCAST_CNT, 1'b0, '0, rdata, err);
      check_value("broadcast counter after clear", bcast_seen, rdata);
      apb_access(`REG_STALL_CNT, 1'b0, '0, rdata, err);
      check_value("stall counter after clear", stall_seen, rdata);
      // unmapped address
      apb_access(8'h0c, 1'b0, '0, rdata, err);
      check_value("address 0xc pslverr", 1, err);
      check_value("address 0xc read data", 0, rdata);

      missing = 0;
      foreach (exp_kind[s]) begin
         if (exp_kind[s] != 0) missing++;
      end
      if (missing == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         report_error($sformatf("%0d expected broadcasts never appeared on the CDB", missing));
      end
   end

endmodule

// File: build.f
+incdir+source
source/issue_pkg.sv
source/int_alu.sv
source/ls_data_cache.sv
source/mult_pipe.sv
source/div_pipe.sv
source/cdb_arbiter.sv
source/issue_regs.sv
source/issue_unit.sv
tests/issue_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the issue_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -Wno-fatal -f build.f \
   --top-module issue_unit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vissue_unit_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
   exit 0
fi
exit 1
